/* src/mcu_pkg.sv */
/*
  Shared types for the teaching sound MCU core: data widths, phase
  sequence, opcode encoding, bus sources and the per-cycle control word.
*/
package mcu_pkg;

  ////////////////////////////////////////////////////////////
  // sizes
  localparam int ROM_DEPTH = 256;        // program words
  localparam int RAM_DEPTH = 16;         // register bytes
  localparam string ROM_FILE = "rom.hex";

  typedef logic [7:0]  data_t;           // internal data bus word
  typedef logic [15:0] inst_t;           // opcode | reg | imm
  typedef logic [7:0]  pc_t;             // program address
  typedef logic [3:0]  reg_addr_t;       // register RAM address

  ////////////////////////////////////////////////////////////
  // machine cycle, one phase per CLK
  typedef enum logic [2:0] {
    PH_ADDR    = 3'd0,                   // pc to rom
    PH_READ    = 3'd1,                   // rom word registered
    PH_LATCH   = 3'd2,                   // word into ir
    PH_DEC     = 3'd3,                   // ram read, pad sample
    PH_DRIVE   = 3'd4,                   // one peer on the bus
    PH_CAPTURE = 3'd5,                   // destinations load
    PH_SPARE   = 3'd6,                   // alu writeback
    PH_ADVANCE = 3'd7                    // pc update
  } phase_e;

  // opcode lives in ir[15:12]
  typedef enum logic [3:0] {
    OP_NOP    = 4'h0,
    OP_IN_PA  = 4'h1,                    // IN A,PA
    OP_OUT_PA = 4'h2,                    // OUT PA,A
    OP_OUT_PB = 4'h3,                    // OUT PB,A
    OP_MVI    = 4'h4,                    // MVI A,n
    OP_ADI    = 4'h5,                    // ADI A,n
    OP_SBI    = 4'h6,                    // SBI A,n
    OP_MOV_RA = 4'h7,                    // MOV Rr,A
    OP_MOV_AR = 4'h8,                    // MOV A,Rr
    OP_JMP    = 4'h9                     // JMP n
  } opcode_e;

  typedef enum logic [2:0] {
    SRC_NONE = 3'd0,
    SRC_IMM  = 3'd1,
    SRC_ACC  = 3'd2,
    SRC_ALU  = 3'd3,
    SRC_RAM  = 3'd4,
    SRC_PAD  = 3'd5
  } bus_src_e;

  typedef struct packed {
    bus_src_e  drive_src;                // who drives db at PH_DRIVE
    logic      load_acc;                 // acc is the destination
    logic      alu_op;                   // acc result goes through the adder
    logic      alu_sub;                  // subtract instead of add
    logic      write_ram;
    reg_addr_t ram_addr;
    logic      load_pa;
    logic      load_pb;
    logic      jump;
  } ctrl_t;

endpackage

/* src/phase_gen.sv */
/*
  Machine-cycle generator. Steps through the eight phases, one per CLK,
  and wraps from PH_ADVANCE back to PH_ADDR.
*/
module phase_gen import mcu_pkg::*; (
  input  logic   CLK,
  input  logic   arst_n,
  output phase_e phase
);

  logic [2:0] cnt;                       // raw phase count

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= 3'd0;                       // restart at PH_ADDR
    end else begin
      cnt <= cnt + 3'd1;                 // wraps after PH_ADVANCE
    end
  end

  assign phase = phase_e'(cnt);

endmodule

/* src/fetch_unit.sv */
/*
  Instruction fetch. Holds the program counter and ROM, latches the
  instruction register and offers the immediate byte on the data bus.
*/
module fetch_unit import mcu_pkg::*; (
  input  logic   CLK,
  input  logic   arst_n,
  input  phase_e phase,
  input  ctrl_t  ctrl,
  output inst_t  ir,
  output logic   imm_req,
  output data_t  imm_data
);

  inst_t rom [ROM_DEPTH];                // program image
  inst_t rom_q;                          // rom read register
  pc_t   pc;

  initial begin
    $readmemh(ROM_FILE, rom);
  end

  ////////////////////////////////////////////////////////////
  // rom read and instruction register

  always_ff @(posedge CLK) begin
    if (phase == PH_READ) begin
      rom_q <= rom[pc];                  // pc was presented in PH_ADDR
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      ir <= '0;                          // decodes as OP_NOP
    end else if (phase == PH_LATCH) begin
      ir <= rom_q;
    end
  end

  ////////////////////////////////////////////////////////////
  // program counter

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      pc <= '0;
    end else if (phase == PH_ADVANCE) begin
      if (ctrl.jump) begin
        pc <= pc_t'(ir[7:0]);            // jump target
      end else begin
        pc <= pc + 8'd1;
      end
    end
  end

  // immediate operand for MVI / ADI / SBI
  assign imm_req  = (phase == PH_DRIVE) && (ctrl.drive_src == SRC_IMM);
  assign imm_data = ir[7:0];

  // a missing or short program image shows up as an unknown word
  a_ir_known : assert property (
    @(posedge CLK) disable iff (!arst_n)
    phase == PH_DEC |-> !$isunknown(ir)
  ) else $error("instruction register holds an unknown word");

endmodule

/* src/inst_decode.sv */
/*
  Instruction decoder. Maps the opcode in the instruction register to
  a bus source, destination enables and the ALU direction.
*/
module inst_decode import mcu_pkg::*; (
  input  inst_t ir,
  output ctrl_t ctrl
);

  opcode_e op;

  assign op = opcode_e'(ir[15:12]);

  always_comb begin
    ctrl           = '0;
    ctrl.drive_src = SRC_NONE;
    ctrl.ram_addr  = reg_addr_t'(ir[11:8]); // register number field

    case (op)
      OP_IN_PA: begin
        ctrl.drive_src = SRC_PAD;
        ctrl.load_acc  = 1'b1;
      end
      OP_OUT_PA: begin
        ctrl.drive_src = SRC_ACC;
        ctrl.load_pa   = 1'b1;
      end
      OP_OUT_PB: begin
        ctrl.drive_src = SRC_ACC;
        ctrl.load_pb   = 1'b1;
      end
      OP_MVI: begin
        ctrl.drive_src = SRC_IMM;
        ctrl.load_acc  = 1'b1;
      end
      OP_ADI, OP_SBI: begin
        ctrl.drive_src = SRC_IMM;        // operand comes from ir[7:0]
        ctrl.load_acc  = 1'b1;
        ctrl.alu_op    = 1'b1;
        ctrl.alu_sub   = (op == OP_SBI);
      end
      OP_MOV_RA: begin
        ctrl.drive_src = SRC_ACC;
        ctrl.write_ram = 1'b1;
      end
      OP_MOV_AR: begin
        ctrl.drive_src = SRC_RAM;
        ctrl.load_acc  = 1'b1;
      end
      OP_JMP: begin
        ctrl.jump = 1'b1;                // pc loads at PH_ADVANCE
      end
      default: begin
        ctrl.drive_src = SRC_NONE;       // OP_NOP and unused codes
      end
    endcase
  end

endmodule

/* src/db_arbiter.sv */
/*
  Data bus arbiter. Grants the shared bus by fixed priority and holds
  the last driven value while nobody requests it.
*/
module db_arbiter import mcu_pkg::*; (
  input  logic  CLK,
  input  logic  arst_n,
  input  logic  imm_req,
  input  data_t imm_data,
  input  logic  alu_req,
  input  data_t alu_data,
  input  logic  acc_req,
  input  data_t acc_data,
  input  logic  ram_req,
  input  data_t ram_data,
  input  logic  pad_req,
  input  data_t pad_data,
  output data_t db
);

  bus_src_e grant;
  logic     db_valid;                    // some peer owns the bus
  data_t    db_q;                        // bus keeper

  always_comb begin
    if (imm_req)      grant = SRC_IMM;
    else if (alu_req) grant = SRC_ALU;
    else if (acc_req) grant = SRC_ACC;
    else if (ram_req) grant = SRC_RAM;
    else if (pad_req) grant = SRC_PAD;
    else              grant = SRC_NONE;
  end

  assign db_valid = (grant != SRC_NONE);

  always_comb begin
    case (grant)
      SRC_IMM: db = imm_data;
      SRC_ALU: db = alu_data;
      SRC_ACC: db = acc_data;
      SRC_RAM: db = ram_data;
      SRC_PAD: db = pad_data;
      default: db = db_q;                // hold, read at PH_CAPTURE
    endcase
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      db_q <= '0;
    end else if (db_valid) begin
      db_q <= db;
    end
  end

  // decoder names one source, so only one peer may ask at a time
  a_one_req : assert property (
    @(posedge CLK) disable iff (!arst_n)
    $onehot0({imm_req, alu_req, acc_req, ram_req, pad_req})
  ) else $error("more than one data bus request");

endmodule

/* src/alu_acc.sv */
/*
  Accumulator and 8-bit add/subtract unit. Immediate operands are
  captured at PH_CAPTURE and the result written back at PH_SPARE.
*/
module alu_acc import mcu_pkg::*; (
  input  logic   CLK,
  input  logic   arst_n,
  input  phase_e phase,
  input  ctrl_t  ctrl,
  input  data_t  db,
  output logic   acc_req,
  output data_t  acc_data,
  output logic   alu_req,
  output data_t  alu_data
);

  data_t acc;
  data_t operand;                        // immediate for ADI / SBI
  data_t result;

  // modulo 256, carry dropped
  assign result = ctrl.alu_sub ? (acc - operand) : (acc + operand);

  always_ff @(posedge CLK) begin
    if (phase == PH_CAPTURE && ctrl.alu_op) begin
      operand <= db;
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      acc <= '0;
    end else if (phase == PH_CAPTURE && ctrl.load_acc && !ctrl.alu_op) begin
      acc <= db;                         // IN, MVI, MOV A,Rr
    end else if (phase == PH_SPARE && ctrl.load_acc && ctrl.alu_op) begin
      acc <= result;                     // ADI / SBI writeback
    end
  end

  assign acc_req  = (phase == PH_DRIVE) && (ctrl.drive_src == SRC_ACC);
  assign acc_data = acc;
  assign alu_req  = (phase == PH_DRIVE) && (ctrl.drive_src == SRC_ALU);
  assign alu_data = result;

endmodule

/* src/reg_ram.sv */
/*
  16 x 8 register RAM. Reads into a buffer at PH_DEC and writes the
  data bus at PH_CAPTURE.
*/
module reg_ram import mcu_pkg::*; (
  input  logic   CLK,
  input  logic   arst_n,
  input  phase_e phase,
  input  ctrl_t  ctrl,
  input  data_t  db,
  output logic   ram_req,
  output data_t  ram_data
);

  data_t mem [RAM_DEPTH];
  data_t rd_buf;                         // read buffer, on bus at PH_DRIVE

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < RAM_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (phase == PH_CAPTURE && ctrl.write_ram) begin
      mem[ctrl.ram_addr] <= db;          // MOV Rr,A
    end
  end

  always_ff @(posedge CLK) begin
    if (phase == PH_DEC) begin
      rd_buf <= mem[ctrl.ram_addr];
    end
  end

  assign ram_req  = (phase == PH_DRIVE) && (ctrl.drive_src == SRC_RAM);
  assign ram_data = rd_buf;

endmodule

/* src/io_ports.sv */
/*
  Port block. Samples the PA pads for IN A,PA and holds the PA and PB
  output registers loaded by OUT.
*/
module io_ports import mcu_pkg::*; (
  input  logic   CLK,
  input  logic   arst_n,
  input  phase_e phase,
  input  ctrl_t  ctrl,
  input  data_t  db,
  input  data_t  PA_I,
  output logic   pad_req,
  output data_t  pad_data,
  output data_t  PA_O,
  output data_t  PB_O
);

  data_t pa_in;                          // pad sample register

  // sampled on the edge that opens PH_DRIVE
  always_ff @(posedge CLK) begin
    if (phase == PH_DEC) begin
      pa_in <= PA_I;
    end
  end

  assign pad_req  = (phase == PH_DRIVE) && (ctrl.drive_src == SRC_PAD);
  assign pad_data = pa_in;

  ////////////////////////////////////////////////////////////
  // output registers, change on the edge ending PH_CAPTURE

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      PA_O <= '0;
      PB_O <= '0;
    end else if (phase == PH_CAPTURE) begin
      if (ctrl.load_pa) begin
        PA_O <= db;
      end
      if (ctrl.load_pb) begin
        PB_O <= db;
      end
    end
  end

endmodule

/* src/mcu_top.sv */
/*
  Top level of the teaching MCU core. Connects the phase generator,
  decoder, bus arbiter and the peers sharing the data bus.
*/
module mcu_top import mcu_pkg::*; (
  input  logic  CLK,
  input  logic  arst_n,
  input  data_t PA_I,
  output data_t PA_O,
  output data_t PB_O
);

  phase_e phase;
  inst_t  ir;
  ctrl_t  ctrl;
  data_t  db;

  logic   imm_req, alu_req, acc_req, ram_req, pad_req;
  data_t  imm_data, alu_data, acc_data, ram_data, pad_data;

  ////////////////////////////////////////////////////////////
  // sequencing and decode

  phase_gen phase_gen_i (
    .CLK    (CLK),
    .arst_n (arst_n),
    .phase  (phase)
  );

  fetch_unit fetch_unit_i (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .phase    (phase),
    .ctrl     (ctrl),
    .ir       (ir),
    .imm_req  (imm_req),
    .imm_data (imm_data)
  );

  inst_decode inst_decode_i (
    .ir   (ir),
    .ctrl (ctrl)
  );

  ////////////////////////////////////////////////////////////
  // shared data bus and its peers

  db_arbiter db_arbiter_i (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .imm_req  (imm_req),
    .imm_data (imm_data),
    .alu_req  (alu_req),
    .alu_data (alu_data),
    .acc_req  (acc_req),
    .acc_data (acc_data),
    .ram_req  (ram_req),
    .ram_data (ram_data),
    .pad_req  (pad_req),
    .pad_data (pad_data),
    .db       (db)
  );

  alu_acc alu_acc_i (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .phase    (phase),
    .ctrl     (ctrl),
    .db       (db),
    .acc_req  (acc_req),
    .acc_data (acc_data),
    .alu_req  (alu_req),
    .alu_data (alu_data)
  );

  reg_ram reg_ram_i (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .phase    (phase),
    .ctrl     (ctrl),
    .db       (db),
    .ram_req  (ram_req),
    .ram_data (ram_data)
  );

  io_ports io_ports_i (
    .CLK      (CLK),
    .arst_n   (arst_n),
    .phase    (phase),
    .ctrl     (ctrl),
    .db       (db),
    .PA_I     (PA_I),
    .pad_req  (pad_req),
    .pad_data (pad_data),
    .PA_O     (PA_O),
    .PB_O     (PB_O)
  );

endmodule

/* testbench/tb_top.sv */
/*
  Testbench for the teaching MCU core. Runs the loop program in rom.hex
  and checks the PB add path and the PA subtract path for a table of inputs.
*/
module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic [7:0] pa_i;
    logic [7:0] exp_pb;                  // pa_i + 23h
    logic [7:0] exp_pa;                  // pa_i - 11h
  } row_t;

  localparam int FIXED_ROWS = 6;
  localparam int RAND_ROWS  = 10;
  localparam int NUM_ROWS   = FIXED_ROWS + RAND_ROWS;
  localparam int POLL_LIMIT = 200;       // cycles per output wait

  logic        CLK;
  logic        arst_n;
  logic [7:0]  pa_i;
  logic [7:0]  pa_o;
  logic [7:0]  pb_o;

  row_t        table_rows [NUM_ROWS];
  logic [31:0] lcg_state;
  int          checks;
  int          errors;
  int          timeouts;

  mcu_top dut_i (
    .CLK    (CLK),
    .arst_n (arst_n),
    .PA_I   (pa_i),
    .PA_O   (pa_o),
    .PB_O   (pb_o)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error %s: expected %02h, actual %02h", name, expected, actual);
    end
  endtask

  // outputs settle within two passes of the 64-cycle loop
  task automatic wait_outputs(input int row, input row_t r);
    int cycles;
    cycles = 0;
    while ((pb_o !== r.exp_pb || pa_o !== r.exp_pa) && cycles < POLL_LIMIT) begin
      @(negedge CLK);
      cycles++;
    end
    if (pb_o !== r.exp_pb || pa_o !== r.exp_pa) begin
      timeouts++;
      $display("Timed out after %0d cycles waiting for the port outputs of row %0d",
               POLL_LIMIT, row);
    end
  endtask

  initial begin
    logic [7:0] pa;
    checks    = 0;
    errors    = 0;
    timeouts  = 0;
    lcg_state = 32'hc58f74bf;
    arst_n    = 1'b0;
    pa_i      = 8'h00;

    ////////////////////////////////////////////////////////////
    // stimulus table, fixed rows cover both wrap directions
    table_rows[0] = '{8'h00, 8'h23, 8'hef};
    table_rows[1] = '{8'h10, 8'h33, 8'hff};
    table_rows[2] = '{8'h11, 8'h34, 8'h00};
    table_rows[3] = '{8'hdd, 8'h00, 8'hcc}; // add wraps past ffh
    table_rows[4] = '{8'hff, 8'h22, 8'hee};
    table_rows[5] = '{8'h05, 8'h28, 8'hf4}; // sub wraps below 0
    for (int i = FIXED_ROWS; i < NUM_ROWS; i++) begin
      lcg_state = lcg_next(lcg_state);
      pa = lcg_state[23:16];
      if (pa == table_rows[i-1].pa_i) begin
        pa = pa ^ 8'h5a;                 // keep neighbours distinct
      end
      table_rows[i] = '{pa, pa + 8'h23, pa - 8'h11};
    end

    ////////////////////////////////////////////////////////////
    // reset
    repeat (16) @(negedge CLK);
    check_value("reset pa_o", 8'h00, pa_o);
    check_value("reset pb_o", 8'h00, pb_o);
    arst_n = 1'b1;
    // first OUT lands 30 cycles after release
    repeat (29) begin
      @(negedge CLK);
      check_value("reset pa_o", 8'h00, pa_o);
      check_value("reset pb_o", 8'h00, pb_o);
    end

    ////////////////////////////////////////////////////////////
    // add, subtract and jump loop rows
    for (int i = 0; i < NUM_ROWS; i++) begin
      @(negedge CLK);
      pa_i = table_rows[i].pa_i;
      wait_outputs(i, table_rows[i]);
      check_value($sformatf("add_path row %0d", i), table_rows[i].exp_pb, pb_o);
      check_value($sformatf("sub_path row %0d", i), table_rows[i].exp_pa, pa_o);
    end

    // pa_i held, outputs rewritten with the same values
    repeat (64) begin
      @(negedge CLK);
      check_value("output_hold pb_o", table_rows[NUM_ROWS-1].exp_pb, pb_o);
      check_value("output_hold pa_o", table_rows[NUM_ROWS-1].exp_pa, pa_o);
    end

    $display("checks: %0d, value errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* build.f */
src/mcu_pkg.sv
src/phase_gen.sv
src/fetch_unit.sv
src/inst_decode.sv
src/db_arbiter.sv
src/alu_acc.sv
src/reg_ram.sv
src/io_ports.sv
src/mcu_top.sv
testbench/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build the MCU testbench with Verilator, run it and scan the log for failure.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -f build.f --top-module tb_top -o tb_sim \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 \
  || echo "Something failed: simulator returned a nonzero status" >> sim.log
cat sim.log
grep -q "Something failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

/* rom.hex */
// one 16-bit word per line: opcode[15:12] register[11:8] immediate[7:0]
// loop program, addresses 0 to 7
1000 // IN A,PA
7500 // MOV R5,A
5023 // ADI A,23h
3000 // OUT PB,A
8500 // MOV A,R5
6011 // SBI A,11h
2000 // OUT PA,A
9000 // JMP 0
